//--- src/bkm_pkg.sv
/*
 * BKM operand front end, shared definitions
 * Signed digit code and its three legal values, default operand
 * widths and the state encoding of the digit sender FSM
 */
package bkm_pkg;

   // ----------------------------------------------------------------------
   // Signed digit encoding
   // ----------------------------------------------------------------------

   // One CSD digit, two's complement of the digit value
   typedef logic [1:0] csd_digit_t;

   // Digit value 0
   localparam csd_digit_t CSD_ZERO = 2'b00;
   // Digit value +1
   localparam csd_digit_t CSD_POS  = 2'b01;
   // Digit value -1, so code 10 is never produced
   localparam csd_digit_t CSD_NEG  = 2'b11;

   // ----------------------------------------------------------------------
   // Default widths
   // ----------------------------------------------------------------------

   // Argument words x and y
   localparam int WD_DEFAULT = 72;
   // Step coefficients u and v
   localparam int WC_DEFAULT = 21;

   // ----------------------------------------------------------------------
   // Digit sender FSM
   // ----------------------------------------------------------------------

   // IDLE waits for a set, SEND walks the digits MSD first
   typedef enum logic {
      IDLE,
      SEND
   } sender_state_t;

endpackage

//--- src/csd_operand_if.sv
/*
 * Encoded operand set channel
 * Two CSD argument words and two binary coefficients, moved under
 * a valid/ready handshake
 */
`timescale 1ns/1ps

interface csd_operand_if #(
   parameter int WD = bkm_pkg::WD_DEFAULT,
   parameter int WC = bkm_pkg::WC_DEFAULT
);

   // Handshake pair
   logic              valid;
   logic              ready;

   // Argument words, two bits per digit
   logic [2*WD-1:0]   x_csd;
   logic [2*WD-1:0]   y_csd;

   // Coefficients, plain two's complement
   logic [WC-1:0]     u;
   logic [WC-1:0]     v;

   // Producer side
   modport source (output valid, x_csd, y_csd, u, v, input ready);

   // Consumer side
   modport sink (input valid, x_csd, y_csd, u, v, output ready);

endinterface

//--- src/bin2csd.sv
/*
 * Binary to CSD recoder
 * Turns a two's complement word into a non-adjacent form signed digit
 * word of the same value, two bits per digit, purely combinational
 */
`timescale 1ns/1ps

module bin2csd #(
   parameter int WD = bkm_pkg::WD_DEFAULT
) (
   input  logic [WD-1:0]   x,
   output logic [2*WD-1:0] y
);

   // Input with one extra copy of the sign bit on top
   typedef logic [WD:0] ext_word_t;

   ext_word_t x_ext;

   // Sign extension supplies the look-ahead bit for the top digit
   assign x_ext = {x[WD-1], x};

   // ----------------------------------------------------------------------
   // Carry scan, LSB to MSB
   // ----------------------------------------------------------------------
   // Digit i = x[i] + c[i] - 2*c[i+1]
   // c[i+1] = (x[i] + c[i] + x[i+1]) / 2, rounded down
   // With a negative input the final carry cancels the sign weight,
   // so WD digits always hold the whole value
   always_comb begin
      logic                carry;
      logic                next_bit;
      bkm_pkg::csd_digit_t digit;

      carry = 1'b0;
      y     = '0;
      for (int i = 0; i < WD; i++) begin
         next_bit = x_ext[i+1];
         if (x_ext[i] ^ carry) begin
            // Odd partial sum, the digit is nonzero
            if (next_bit) begin
               // Run of ones continues, take -1 and carry up
               digit = bkm_pkg::CSD_NEG;
               carry = 1'b1;
            end else begin
               digit = bkm_pkg::CSD_POS;
               carry = 1'b0;
            end
         end else begin
            // Even partial sum, bit and carry are equal
            digit = bkm_pkg::CSD_ZERO;
            carry = x_ext[i];
         end
         y[2*i +: 2] = digit;
      end
   end

endmodule

//--- src/operand_encoder.sv
/*
 * Operand encoder
 * Accepts binary operand sets, recodes x and y to CSD and holds the
 * result in a one-deep output register, one set per cycle
 */
`timescale 1ns/1ps

module operand_encoder #(
   parameter int WD = bkm_pkg::WD_DEFAULT,
   parameter int WC = bkm_pkg::WC_DEFAULT
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           in_valid,
   output logic           in_ready,
   input  logic [WD-1:0]  x_in,
   input  logic [WD-1:0]  y_in,
   input  logic [WC-1:0]  u_in,
   input  logic [WC-1:0]  v_in,
   csd_operand_if.source  out
);

   typedef logic [2*WD-1:0] csd_word_t;

   csd_word_t x_enc;
   csd_word_t y_enc;
   logic      full_q;
   logic      armed_q;
   logic      load;

   // ----------------------------------------------------------------------
   // Recoders
   // ----------------------------------------------------------------------
   bin2csd #(.WD(WD)) bin2csd_x (.x(x_in), .y(x_enc));
   bin2csd #(.WD(WD)) bin2csd_y (.x(y_in), .y(y_enc));

   // ----------------------------------------------------------------------
   // Output register
   // ----------------------------------------------------------------------

   // Room when empty or draining this cycle, low for one cycle after reset
   assign in_ready  = armed_q && (!full_q || out.ready);
   assign load      = in_valid && in_ready;
   assign out.valid = full_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         armed_q <= 1'b0;
         full_q  <= 1'b0;
      end else begin
         armed_q <= 1'b1;
         if (load)
            full_q <= 1'b1;
         else if (out.ready)
            full_q <= 1'b0;
      end
   end

   // Payload
   always_ff @(posedge clk) begin
      if (load) begin
         out.x_csd <= x_enc;
         out.y_csd <= y_enc;
         out.u     <= u_in;
         out.v     <= v_in;
      end
   end

   // True when any digit holds the unused code
   function automatic logic has_illegal(csd_word_t w);
      logic bad;

      bad = 1'b0;
      for (int i = 0; i < WD; i++) begin
         if (w[2*i +: 2] != bkm_pkg::CSD_ZERO &&
             w[2*i +: 2] != bkm_pkg::CSD_POS &&
             w[2*i +: 2] != bkm_pkg::CSD_NEG)
            bad = 1'b1;
      end
      return bad;
   endfunction

   // Recoder never emits code 10
   a_no_illegal_digit: assert property (@(posedge clk) disable iff (reset)
      out.valid |-> !has_illegal(out.x_csd) && !has_illegal(out.y_csd));

   // Stalled set holds until taken
   a_stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
      out.valid && !out.ready |=> out.valid && $stable(out.x_csd) &&
      $stable(out.y_csd) && $stable(out.u) && $stable(out.v));

endmodule

//--- src/operand_fifo.sv
/*
 * Encoded operand FIFO
 * Circular buffer of DEPTH operand sets between encoder and sender,
 * registered write side, push and pop allowed together when full
 */
`timescale 1ns/1ps

module operand_fifo #(
   parameter int WD    = bkm_pkg::WD_DEFAULT,
   parameter int WC    = bkm_pkg::WC_DEFAULT,
   parameter int DEPTH = 4
) (
   input  logic          clk,
   input  logic          reset,
   csd_operand_if.sink   wr,
   csd_operand_if.source rd
);

   localparam int AW = $clog2(DEPTH);

   // One stored set, x and y words then u and v
   typedef logic [4*WD+2*WC-1:0] entry_t;
   typedef logic [AW-1:0]        ptr_t;
   // One bit wider than the pointers to hold DEPTH itself
   typedef logic [AW:0]          count_t;

   entry_t mem [DEPTH];
   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   count_t count;
   logic   full;
   logic   empty;
   logic   push;
   logic   pop;

   // ----------------------------------------------------------------------
   // Status and handshakes
   // ----------------------------------------------------------------------
   assign full  = (count == count_t'(DEPTH));
   assign empty = (count == '0);

   // Full buffer still takes a set when the head leaves this cycle
   assign wr.ready = !full || rd.ready;
   assign rd.valid = !empty;

   assign push = wr.valid && wr.ready;
   assign pop  = rd.valid && rd.ready;

   // ----------------------------------------------------------------------
   // Storage
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= {wr.x_csd, wr.y_csd, wr.u, wr.v};
   end

   // Head of queue, read straight from the array
   assign {rd.x_csd, rd.y_csd, rd.u, rd.v} = mem[rd_ptr];

   // ----------------------------------------------------------------------
   // Pointers and occupancy
   // ----------------------------------------------------------------------
   // Power of two depth, pointers wrap on their own
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   // A full buffer never grows past DEPTH
   a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      full |=> count <= count_t'(DEPTH));

   // An empty buffer never wraps below zero
   a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
      empty |=> count <= count_t'(1));

endmodule

//--- src/csd_digit_sender.sv
/*
 * CSD digit sender
 * Latches one encoded operand set and sends it as WD digit beats,
 * MSD first, with u and v held for the whole set
 */
`timescale 1ns/1ps

module csd_digit_sender #(
   parameter int WD = bkm_pkg::WD_DEFAULT,
   parameter int WC = bkm_pkg::WC_DEFAULT
) (
   input  logic                clk,
   input  logic                reset,
   csd_operand_if.sink         in,
   output logic                digit_valid,
   input  logic                digit_ready,
   output bkm_pkg::csd_digit_t x_digit,
   output bkm_pkg::csd_digit_t y_digit,
   output logic [WC-1:0]       u_out,
   output logic [WC-1:0]       v_out,
   output logic                digit_last
);

   typedef logic [2*WD-1:0]        csd_word_t;
   typedef logic [$clog2(WD)-1:0]  digit_idx_t;

   bkm_pkg::sender_state_t state;
   digit_idx_t             idx;
   csd_word_t              x_q;
   csd_word_t              y_q;
   logic                   take;
   logic                   beat;

   // ----------------------------------------------------------------------
   // Handshakes
   // ----------------------------------------------------------------------

   // New set only between sets
   assign in.ready    = (state == bkm_pkg::IDLE);
   assign take        = in.valid && in.ready;
   assign digit_valid = (state == bkm_pkg::SEND);
   assign beat        = digit_valid && digit_ready;
   // Digit 0 closes the set
   assign digit_last  = digit_valid && (idx == '0);

   // ----------------------------------------------------------------------
   // FSM and digit index
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= bkm_pkg::IDLE;
         idx   <= '0;
      end else begin
         case (state)
            bkm_pkg::IDLE: begin
               if (take) begin
                  state <= bkm_pkg::SEND;
                  idx   <= digit_idx_t'(WD - 1);
               end
            end
            bkm_pkg::SEND: begin
               // Walk down on each taken beat
               if (beat) begin
                  if (idx == '0)
                     state <= bkm_pkg::IDLE;
                  else
                     idx <= idx - 1'b1;
               end
            end
            default: state <= bkm_pkg::IDLE;
         endcase
      end
   end

   // Latched set
   always_ff @(posedge clk) begin
      if (take) begin
         x_q   <= in.x_csd;
         y_q   <= in.y_csd;
         u_out <= in.u;
         v_out <= in.v;
      end
   end

   // ----------------------------------------------------------------------
   // Beat data
   // ----------------------------------------------------------------------
   assign x_digit = x_q[2*idx +: 2];
   assign y_digit = y_q[2*idx +: 2];

   // No beat follows a taken end marker
   a_last_with_valid: assert property (@(posedge clk) disable iff (reset)
      digit_last && digit_ready |=> !digit_valid);

   // Held beat keeps its digit and position
   a_beat_stable: assert property (@(posedge clk) disable iff (reset)
      digit_valid && !digit_ready |=> digit_valid && $stable(idx) &&
      $stable(x_digit) && $stable(y_digit));

endmodule

//--- src/bkm_operand_driver.sv
/*
 * BKM operand driver top level
 * Encoder, operand FIFO and digit sender in a row, binary operand
 * sets in, CSD digit beats out
 */
`timescale 1ns/1ps

module bkm_operand_driver #(
   parameter int WD    = bkm_pkg::WD_DEFAULT,
   parameter int WC    = bkm_pkg::WC_DEFAULT,
   parameter int DEPTH = 4
) (
   input  logic                clk,
   input  logic                reset,
   // Binary operand input
   input  logic                in_valid,
   output logic                in_ready,
   input  logic [WD-1:0]       x_in,
   input  logic [WD-1:0]       y_in,
   input  logic [WC-1:0]       u_in,
   input  logic [WC-1:0]       v_in,
   // Digit output
   output logic                digit_valid,
   input  logic                digit_ready,
   output bkm_pkg::csd_digit_t x_digit,
   output bkm_pkg::csd_digit_t y_digit,
   output logic [WC-1:0]       u_out,
   output logic [WC-1:0]       v_out,
   output logic                digit_last
);

   // ----------------------------------------------------------------------
   // Internal channels
   // ----------------------------------------------------------------------
   // Encoder to FIFO
   csd_operand_if #(.WD(WD), .WC(WC)) enc_if ();
   // FIFO to sender
   csd_operand_if #(.WD(WD), .WC(WC)) buf_if ();

   operand_encoder #(.WD(WD), .WC(WC)) i_encoder (
      .clk      (clk),
      .reset    (reset),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .x_in     (x_in),
      .y_in     (y_in),
      .u_in     (u_in),
      .v_in     (v_in),
      .out      (enc_if)
   );

   operand_fifo #(.WD(WD), .WC(WC), .DEPTH(DEPTH)) i_fifo (
      .clk   (clk),
      .reset (reset),
      .wr    (enc_if),
      .rd    (buf_if)
   );

   csd_digit_sender #(.WD(WD), .WC(WC)) i_sender (
      .clk         (clk),
      .reset       (reset),
      .in          (buf_if),
      .digit_valid (digit_valid),
      .digit_ready (digit_ready),
      .x_digit     (x_digit),
      .y_digit     (y_digit),
      .u_out       (u_out),
      .v_out       (v_out),
      .digit_last  (digit_last)
   );

endmodule

//--- bench/tb_bkm_operand_driver.sv
/*
 * Testbench for the BKM operand driver
 * Directed tests push binary operand sets in, collect the digit beats
 * and compare them with a reference NAF recoder
 */
`timescale 1ns/1ps

module tb_bkm_operand_driver;

   localparam int WD      = 72;
   localparam int WC      = 21;
   localparam int DEPTH   = 4;
   localparam int TIMEOUT = 2000;

   // Two spare bits for reference arithmetic
   typedef logic [WD+1:0]   ext_t;
   typedef logic [2*WD-1:0] csd_word_t;

   logic                clk = 1'b0;
   logic                reset;
   logic                in_valid;
   logic                in_ready;
   logic [WD-1:0]       x_in;
   logic [WD-1:0]       y_in;
   logic [WC-1:0]       u_in;
   logic [WC-1:0]       v_in;
   logic                digit_valid;
   logic                digit_ready;
   bkm_pkg::csd_digit_t x_digit;
   bkm_pkg::csd_digit_t y_digit;
   logic [WC-1:0]       u_out;
   logic [WC-1:0]       v_out;
   logic                digit_last;

   // Sets still to send, then sets sent but not yet received
   logic [WD-1:0] src_x[$], src_y[$], exp_x[$], exp_y[$];
   logic [WC-1:0] src_u[$], src_v[$], exp_u[$], exp_v[$];

   logic [31:0] rng_state = 32'h7332a771;
   int          test_errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   bit          saw_stall;

   bkm_operand_driver #(.WD(WD), .WC(WC), .DEPTH(DEPTH)) i_dut (.*);

   always #10 clk = ~clk;

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   // xorshift32
   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic [WD-1:0] random_word();
      logic [95:0] r;
      r = {next_random(), next_random(), next_random()};
      return r[WD-1:0];
   endfunction

   function automatic logic [WC-1:0] random_coef();
      logic [31:0] r;
      r = next_random();
      return r[WC-1:0];
   endfunction

   // Textbook NAF, subtract the odd residue and halve
   function automatic csd_word_t ref_naf(input logic [WD-1:0] v);
      ext_t      n;
      csd_word_t w;
      n = {{2{v[WD-1]}}, v};
      w = '0;
      for (int i = 0; i < WD; i++) begin
         if (n[0]) begin
            // n mod 4 == 3 gives -1
            if (n[1]) begin
               w[2*i +: 2] = bkm_pkg::CSD_NEG;
               n = n + ext_t'(1);
            end else begin
               w[2*i +: 2] = bkm_pkg::CSD_POS;
               n = n - ext_t'(1);
            end
         end
         n = {n[WD+1], n[WD+1:1]};
      end
      return w;
   endfunction

   // Signed value of a digit word, weight 2^i per digit
   function automatic ext_t digit_sum(input csd_word_t w);
      ext_t acc;
      acc = '0;
      for (int i = 0; i < WD; i++) begin
         if (w[2*i +: 2] == bkm_pkg::CSD_POS)
            acc = acc + (ext_t'(1) << i);
         else if (w[2*i +: 2] == bkm_pkg::CSD_NEG)
            acc = acc - (ext_t'(1) << i);
      end
      return acc;
   endfunction

   // Neighbouring nonzero pairs, zero for a valid NAF
   function automatic int count_adjacent(input csd_word_t w);
      int n;
      n = 0;
      for (int i = 0; i < WD - 1; i++) begin
         if (w[2*i +: 2] != 2'b00 && w[2*i+2 +: 2] != 2'b00)
            n++;
      end
      return n;
   endfunction

   function automatic int count_illegal(input csd_word_t w);
      int n;
      n = 0;
      for (int i = 0; i < WD; i++) begin
         if (w[2*i +: 2] == 2'b10)
            n++;
      end
      return n;
   endfunction

   task automatic check_equal(input string name, input logic [2*WD-1:0] expected,
                              input logic [2*WD-1:0] actual);
      if (expected !== actual) begin
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic end_test(input string name);
      if (test_errors == 0) begin
         pass_count++;
         $display("%s: PASS", name);
      end else begin
         fail_count++;
         $display("%s: FAIL with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic add_set(input logic [WD-1:0] x, input logic [WD-1:0] y);
      src_x.push_back(x);
      src_y.push_back(y);
      src_u.push_back(random_coef());
      src_v.push_back(random_coef());
   endtask

   // ----------------------------------------------------------------------
   // Driver and collector
   // ----------------------------------------------------------------------
   // in_valid stays high across the whole list
   task automatic send_all(input string name);
      int wait_cycles;
      while (src_x.size() > 0) begin
         @(negedge clk);
         in_valid = 1'b1;
         x_in     = src_x[0];
         y_in     = src_y[0];
         u_in     = src_u[0];
         v_in     = src_v[0];
         wait_cycles = 0;
         while (!in_ready && wait_cycles < TIMEOUT) begin
            saw_stall = 1'b1;
            @(negedge clk);
            wait_cycles++;
         end
         if (!in_ready) begin
            $display("Timeout in %s: input set never accepted", name);
            test_errors++;
            break;
         end
         // Taken on the coming rising edge
         exp_x.push_back(src_x.pop_front());
         exp_y.push_back(src_y.pop_front());
         exp_u.push_back(src_u.pop_front());
         exp_v.push_back(src_v.pop_front());
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // One set of WD beats, MSD first
   task automatic collect_set(input string name, input bit gaps);
      csd_word_t     xw, yw;
      logic [WD-1:0] ex, ey;
      logic [WC-1:0] eu, ev;
      int            beats, wait_cycles;
      bit            got;
      xw = '0;
      yw = '0;
      beats = 0;
      while (beats < WD) begin
         wait_cycles = 0;
         got = 1'b0;
         while (!got && wait_cycles < TIMEOUT) begin
            @(negedge clk);
            digit_ready = gaps ? (next_random() % 4 != 0) : 1'b1;
            if (digit_valid && digit_ready)
               got = 1'b1;
            else
               wait_cycles++;
         end
         if (!got) begin
            $display("Timeout in %s: no digit beat arrived", name);
            test_errors++;
            return;
         end
         if (beats == 0) begin
            if (exp_x.size() == 0) begin
               $display("Error in %s: digit beat with no set sent", name);
               test_errors++;
               return;
            end
            ex = exp_x[0];
            ey = exp_y[0];
            eu = exp_u[0];
            ev = exp_v[0];
         end
         check_equal({name, " u_out"}, eu, u_out);
         check_equal({name, " v_out"}, ev, v_out);
         check_equal({name, " digit_last"}, beats == WD - 1, digit_last);
         xw[2*(WD-1-beats) +: 2] = x_digit;
         yw[2*(WD-1-beats) +: 2] = y_digit;
         beats++;
      end
      void'(exp_x.pop_front());
      void'(exp_y.pop_front());
      void'(exp_u.pop_front());
      void'(exp_v.pop_front());
      // Whole set against the reference
      check_equal({name, " x digits"}, ref_naf(ex), xw);
      check_equal({name, " y digits"}, ref_naf(ey), yw);
      check_equal({name, " x value"}, {{2{ex[WD-1]}}, ex}, digit_sum(xw));
      check_equal({name, " y value"}, {{2{ey[WD-1]}}, ey}, digit_sum(yw));
      check_equal({name, " adjacent nonzero"}, 0, count_adjacent(xw) + count_adjacent(yw));
      check_equal({name, " illegal code"}, 0, count_illegal(xw) + count_illegal(yw));
   endtask

   // Sends every queued set and collects the same number back
   task automatic run_sets(input string name, input bit gaps);
      int n;
      n = src_x.size();
      fork
         send_all(name);
         begin
            for (int k = 0; k < n; k++)
               collect_set(name, gaps);
         end
      join
      // No duplicated set trailing behind
      repeat (4) begin
         @(negedge clk);
         digit_ready = 1'b0;
         check_equal({name, " extra beat"}, 0, digit_valid);
      end
      check_equal({name, " sets missing"}, 0, exp_x.size());
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic test_reset();
      int wait_cycles;
      repeat (5) @(negedge clk);
      check_equal("reset in_ready", 0, in_ready);
      check_equal("reset digit_valid", 0, digit_valid);
      check_equal("reset digit_last", 0, digit_last);
      reset = 1'b0;
      wait_cycles = 0;
      while (!in_ready && wait_cycles < TIMEOUT) begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!in_ready) begin
         $display("Timeout in reset: in_ready never rose after reset");
         test_errors++;
      end
      check_equal("reset idle digit_valid", 0, digit_valid);
      end_test("reset");
   endtask

   task automatic test_fixed();
      logic [WD-1:0] vals[9];
      vals[0] = '0;
      vals[1] = WD'(1);
      vals[2] = '1;
      vals[3] = WD'(3);
      vals[4] = WD'(7);
      vals[5] = {1'b1, {(WD-1){1'b0}}};
      vals[6] = {1'b0, {(WD-1){1'b1}}};
      vals[7] = {(WD/2){2'b10}};
      vals[8] = {(WD/2){2'b01}};
      foreach (vals[i])
         add_set(vals[i], ~vals[i]);
      run_sets("fixed", 1'b0);
      end_test("fixed");
   endtask

   task automatic test_random();
      for (int k = 0; k < 50; k++)
         add_set(random_word(), random_word());
      run_sets("random", 1'b0);
      end_test("random");
   endtask

   // Lone LSD then lone MSD shows the beat order
   task automatic test_order();
      add_set(WD'(1), {2'b01, {(WD-2){1'b0}}});
      add_set({2'b01, {(WD-2){1'b0}}}, WD'(2));
      run_sets("order", 1'b0);
      end_test("order");
   endtask

   task automatic test_backpressure();
      saw_stall = 1'b0;
      for (int k = 0; k < 12; k++)
         add_set(random_word(), random_word());
      run_sets("backpressure", 1'b1);
      check_equal("backpressure in_ready fell", 1, saw_stall);
      end_test("backpressure");
   endtask

   initial begin
      reset       = 1'b1;
      in_valid    = 1'b0;
      x_in        = '0;
      y_in        = '0;
      u_in        = '0;
      v_in        = '0;
      digit_ready = 1'b0;
      saw_stall   = 1'b0;

      test_reset();
      test_fixed();
      test_random();
      test_order();
      test_backpressure();

      $display("pass count %0d, fail count %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- list.f
src/bkm_pkg.sv
src/csd_operand_if.sv
src/bin2csd.sv
src/operand_encoder.sv
src/operand_fifo.sv
src/csd_digit_sender.sv
src/bkm_operand_driver.sv
bench/tb_bkm_operand_driver.sv

//--- run.sh
#!/bin/sh
# Build the BKM operand driver testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_bkm_operand_driver -f list.f

output=$(./obj_dir/Vtb_bkm_operand_driver)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   exit 0
else
   exit 1
fi
